//--- hdl/dct_pkg.sv
package dct_pkg;

    // sample, coefficient and address types
    typedef logic signed [15:0] sample_t;   // signed 7q8 sample or intermediate value
    typedef logic [8:0]         coeff_t;    // unsigned 7q8 coefficient
    typedef logic [2:0]         elem_addr_t;
    typedef logic [4:0]         spad_addr_t;
    typedef logic [5:0]         upc_t;

    // multiplier coefficients that also index COEFF_7Q8
    typedef enum logic [2:0] {
        c3_cos      = 3'd0,     // cos(3pi/16)
        c3_sin      = 3'd1,
        c1_cos      = 3'd2,     // cos(pi/16)
        c1_sin      = 3'd3,
        r2c6_cos    = 3'd4,     // sqrt2 * cos(6pi/16)
        r2c6_sin    = 3'd5,
        sqrt2       = 3'd6,
        sqrt2_over4 = 3'd7
    } coeff_sel_e;

    typedef enum logic {src_fetch, src_spad} read_src_e;

    // latch source and second adder operand source
    typedef enum logic {from_bus, from_mul} op_src_e;

    typedef enum logic {to_spad, to_result} write_dest_e;

    typedef enum logic {from_adder, from_product} write_src_e;

    // one microcode step of 22 bits
    typedef struct packed {
        spad_addr_t  read_addr;     // low 3 bits double as the input element index
        read_src_e   read_src;
        logic        latch_op1;
        logic        neg_op1;
        logic        neg_op2;
        op_src_e     op1_src;       // what the operand latch loads
        op_src_e     op2_src;
        coeff_sel_e  coeff_sel;     // pairs with the data on the bus in this step
        spad_addr_t  write_addr;
        write_dest_e write_dest;
        logic        write_en;
        write_src_e  write_src;
    } ucode_t;

    // program counter saturates here
    localparam upc_t UCODE_LEN = 6'd49;

    // product shows up this many steps after operand and coefficient
    localparam int MUL_STAGES = 2;

    // rounded to 7q8 in coeff_sel_e order
    localparam coeff_t COEFF_7Q8 [8] = '{
        9'd213,     // 0.8315
        9'd142,     // 0.5556
        9'd251,     // 0.9808
        9'd50,      // 0.1951
        9'd139,     // 0.5412
        9'd334,     // 1.3066
        9'd362,     // 1.4142
        9'd91       // 0.3536
    };

endpackage

//--- hdl/dct_multiplier.sv
`timescale 1ns/1ps

module dct_multiplier (
    input  logic             clock,
    input  dct_pkg::sample_t operand,
    input  dct_pkg::coeff_t  coeff,
    output dct_pkg::sample_t product
);
    import dct_pkg::*;

    sample_t            operand_q;
    coeff_t             coeff_q;
    logic signed [25:0] full;                   // 16 x 10 bit signed product
    sample_t            pipe_q [MUL_STAGES-1];  // product stages after the input registers

    // zero extend the unsigned coefficient before the signed multiply
    assign full = operand_q * $signed({1'b0, coeff_q});

    always_ff @(posedge clock) begin
        operand_q <= operand;
        coeff_q   <= coeff;
        pipe_q[0] <= full[23:8];    // back to 7q8
        for (int i = 1; i < MUL_STAGES - 1; i++) begin
            pipe_q[i] <= pipe_q[i - 1];
        end
    end

    assign product = pipe_q[MUL_STAGES-2];

endmodule

//--- hdl/dct_scratchpad.sv
`timescale 1ns/1ps

module dct_scratchpad #(
    parameter int SPAD_DEPTH = 24
) (
    input  logic                clock,
    input  dct_pkg::spad_addr_t read_addr,
    output dct_pkg::sample_t    read_data,
    input  logic                write_en,
    input  dct_pkg::spad_addr_t write_addr,
    input  dct_pkg::sample_t    write_data
);
    import dct_pkg::*;

    // intermediate flowgraph values, sp0..sp23
    sample_t mem [SPAD_DEPTH];

    always_ff @(posedge clock) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
        read_data <= mem[read_addr];    // old value if the same entry is written now
    end

endmodule

//--- hdl/dct_control.sv
`timescale 1ns/1ps

module dct_control (
    input  logic            clock,
    input  logic            nreset,
    output dct_pkg::ucode_t uop,
    output logic            finished
);
    import dct_pkg::*;

    // steps 0..11 read the input buffer, everything after reads the scratchpad
    localparam upc_t FETCH_STEPS = 6'd12;

    upc_t pc;

    // mark a step as writing the adder or product result somewhere
    function automatic ucode_t spad_wr(ucode_t w, spad_addr_t addr);
        ucode_t r;
        r            = w;
        r.write_en   = 1'b1;
        r.write_dest = to_spad;
        r.write_addr = addr;
        return r;
    endfunction

    function automatic ucode_t out_wr(ucode_t w, elem_addr_t idx);
        ucode_t r;
        r            = w;
        r.write_en   = 1'b1;
        r.write_dest = to_result;
        r.write_addr = {2'b00, idx};
        return r;
    endfunction

    always_ff @(posedge clock) begin
        if (nreset) begin
            pc <= '0;
        end else if (pc != UCODE_LEN) begin
            pc <= pc + 6'd1;
        end
    end

    assign finished = (pc == UCODE_LEN) || (pc == UCODE_LEN - 6'd1);

    // data read in step k is on the bus in step k+1, and a product
    // of the bus in step k (with that step's coeff_sel) is ready in step k+2.
    // Scratchpad writes land at the end of the step, so they can be read the next one.
    always_comb begin
        uop = '0;

        uop.read_src = (pc < FETCH_STEPS) ? src_fetch : src_spad;

        case (pc)
            // input butterflies read each pair as x_i, x_7-i, x_7-i
            6'd0:    uop.read_addr = 5'd0;
            6'd1:    uop.read_addr = 5'd7;
            6'd2:    uop.read_addr = 5'd7;
            6'd3:    uop.read_addr = 5'd1;
            6'd4:    uop.read_addr = 5'd6;
            6'd5:    uop.read_addr = 5'd6;
            6'd6:    uop.read_addr = 5'd2;
            6'd7:    uop.read_addr = 5'd5;
            6'd8:    uop.read_addr = 5'd5;
            6'd9:    uop.read_addr = 5'd3;
            6'd10:   uop.read_addr = 5'd4;
            6'd11:   uop.read_addr = 5'd4;
            // even butterflies
            6'd12:   uop.read_addr = 5'd1;
            6'd13:   uop.read_addr = 5'd2;
            6'd14:   uop.read_addr = 5'd2;
            6'd15:   uop.read_addr = 5'd0;
            6'd16:   uop.read_addr = 5'd3;
            6'd17:   uop.read_addr = 5'd3;
            // rotations by pi/16 and 3pi/16
            6'd18:   uop.read_addr = 5'd5;
            6'd19:   uop.read_addr = 5'd6;
            6'd20:   uop.read_addr = 5'd5;
            6'd21:   uop.read_addr = 5'd6;
            6'd22:   uop.read_addr = 5'd4;
            6'd23:   uop.read_addr = 5'd7;
            6'd24:   uop.read_addr = 5'd4;
            6'd25:   uop.read_addr = 5'd7;
            // even outputs
            6'd26:   uop.read_addr = 5'd10;
            6'd27:   uop.read_addr = 5'd11;
            6'd28:   uop.read_addr = 5'd10;
            6'd29:   uop.read_addr = 5'd11;
            6'd30:   uop.read_addr = 5'd8;
            6'd31:   uop.read_addr = 5'd9;
            6'd32:   uop.read_addr = 5'd9;
            // step 33 reads nothing and only latches the scaled sp8
            6'd34:   uop.read_addr = 5'd13;
            6'd35:   uop.read_addr = 5'd15;
            6'd36:   uop.read_addr = 5'd15;
            6'd37:   uop.read_addr = 5'd12;
            6'd38:   uop.read_addr = 5'd14;
            6'd39:   uop.read_addr = 5'd14;
            6'd40:   uop.read_addr = 5'd20;
            6'd41:   uop.read_addr = 5'd23;
            6'd42:   uop.read_addr = 5'd23;
            6'd43:   uop.read_addr = 5'd21;
            6'd44:   uop.read_addr = 5'd22;
            default: uop.read_addr = 5'd0;
        endcase

        case (pc)
            6'd19, 6'd22:        uop.coeff_sel = c1_cos;
            6'd20, 6'd21:        uop.coeff_sel = c1_sin;
            6'd23, 6'd26:        uop.coeff_sel = c3_cos;
            6'd24, 6'd25:        uop.coeff_sel = c3_sin;
            6'd27, 6'd30:        uop.coeff_sel = r2c6_cos;
            6'd28, 6'd29:        uop.coeff_sel = r2c6_sin;
            6'd44, 6'd45:        uop.coeff_sel = sqrt2;
            default:             uop.coeff_sel = sqrt2_over4;   // 31..33 use this one
        endcase

        // operand latch loads at the end of these steps
        uop.latch_op1 = pc inside {6'd1, 6'd4, 6'd7, 6'd10, 6'd13, 6'd16, 6'd35, 6'd38, 6'd41,
                                   6'd21, 6'd23, 6'd25, 6'd27, 6'd29, 6'd31, 6'd33};
        uop.op1_src   = (pc inside {6'd21, 6'd23, 6'd25, 6'd27, 6'd29, 6'd31, 6'd33}) ?
                        from_mul : from_bus;

        uop.neg_op1   = pc inside {6'd24, 6'd28, 6'd32, 6'd37, 6'd43};
        uop.neg_op2   = pc inside {6'd3, 6'd6, 6'd9, 6'd12, 6'd15, 6'd18, 6'd35, 6'd40};
        uop.op2_src   = (pc inside {6'd22, 6'd24, 6'd26, 6'd28, 6'd30, 6'd32, 6'd34, 6'd35}) ?
                        from_mul : from_bus;
        uop.write_src = (pc inside {6'd46, 6'd47}) ? from_product : from_adder;

        case (pc)
            6'd2:    uop = spad_wr(uop, 5'd0);     // x0 + x7
            6'd3:    uop = spad_wr(uop, 5'd7);     // x0 - x7
            6'd5:    uop = spad_wr(uop, 5'd1);
            6'd6:    uop = spad_wr(uop, 5'd6);
            6'd8:    uop = spad_wr(uop, 5'd2);
            6'd9:    uop = spad_wr(uop, 5'd5);
            6'd11:   uop = spad_wr(uop, 5'd3);
            6'd12:   uop = spad_wr(uop, 5'd4);     // x3 - x4
            6'd14:   uop = spad_wr(uop, 5'd9);     // sp1 + sp2
            6'd15:   uop = spad_wr(uop, 5'd10);
            6'd17:   uop = spad_wr(uop, 5'd8);     // sp0 + sp3
            6'd18:   uop = spad_wr(uop, 5'd11);
            6'd22:   uop = spad_wr(uop, 5'd13);
            6'd24:   uop = spad_wr(uop, 5'd14);
            6'd26:   uop = spad_wr(uop, 5'd12);
            6'd28:   uop = spad_wr(uop, 5'd15);
            6'd30:   uop = out_wr(uop, 3'd2);
            6'd32:   uop = out_wr(uop, 3'd6);
            6'd34:   uop = out_wr(uop, 3'd0);
            6'd35:   uop = out_wr(uop, 3'd4);
            6'd36:   uop = spad_wr(uop, 5'd23);    // sp13 + sp15
            6'd37:   uop = spad_wr(uop, 5'd21);    // sp15 - sp13
            6'd39:   uop = spad_wr(uop, 5'd20);
            6'd40:   uop = spad_wr(uop, 5'd22);
            6'd42:   uop = out_wr(uop, 3'd1);
            6'd43:   uop = out_wr(uop, 3'd7);
            6'd46:   uop = out_wr(uop, 3'd3);      // product straight out
            6'd47:   uop = out_wr(uop, 3'd5);
            default: ;
        endcase
    end

endmodule

//--- hdl/dct_datapath.sv
`timescale 1ns/1ps

module dct_datapath (
    input  logic                clock,
    input  logic                nreset,
    input  dct_pkg::ucode_t     uop,
    output dct_pkg::elem_addr_t fetch_addr,
    input  dct_pkg::sample_t    src_data,
    output dct_pkg::spad_addr_t spad_read_addr,
    input  dct_pkg::sample_t    spad_read_data,
    output logic                spad_wren,
    output dct_pkg::spad_addr_t spad_write_addr,
    output dct_pkg::sample_t    spad_write_data,
    output logic                result_wren,
    output dct_pkg::elem_addr_t result_addr,
    output dct_pkg::sample_t    result_data
);
    import dct_pkg::*;

    read_src_e bus_src_q;   // source of the read issued last step
    sample_t   op_bus;
    sample_t   op_latch;
    sample_t   product;
    sample_t   op2;
    sample_t   op1_term;
    sample_t   op2_term;
    sample_t   sum;
    sample_t   write_value;
    coeff_t    coeff;

    assign fetch_addr     = uop.read_addr[2:0];
    assign spad_read_addr = uop.read_addr;

    // both memories answer one cycle late, so the mux follows last step's read_src
    assign op_bus = (bus_src_q == src_spad) ? spad_read_data : src_data;

    assign coeff = COEFF_7Q8[uop.coeff_sel];

    dct_multiplier mul0 (
        .clock   (clock),
        .operand (op_bus),
        .coeff   (coeff),
        .product (product)
    );

    always_ff @(posedge clock) begin
        if (nreset) begin
            bus_src_q <= src_fetch;
            op_latch  <= '0;
        end else begin
            bus_src_q <= uop.read_src;
            if (uop.latch_op1) begin
                op_latch <= (uop.op1_src == from_mul) ? product : op_bus;
            end
        end
    end

    // add/subtract unit
    assign op2      = (uop.op2_src == from_mul) ? product : op_bus;
    assign op1_term = uop.neg_op1 ? -op_latch : op_latch;
    assign op2_term = uop.neg_op2 ? -op2 : op2;
    assign sum      = op1_term + op2_term;

    assign write_value = (uop.write_src == from_product) ? product : sum;

    // data is only meaningful with its strobe
    assign spad_wren       = uop.write_en && (uop.write_dest == to_spad);
    assign spad_write_addr = uop.write_addr;
    assign spad_write_data = write_value;

    assign result_wren = uop.write_en && (uop.write_dest == to_result);
    assign result_addr = uop.write_addr[2:0];
    assign result_data = write_value;

endmodule

//--- hdl/loeffler_dct_8.sv
`timescale 1ns/1ps

module loeffler_dct_8 #(
    parameter int SPAD_DEPTH = 24
) (
    input  logic                clock,
    input  logic                nreset,
    output dct_pkg::elem_addr_t fetch_addr,
    input  dct_pkg::sample_t    src_data,
    output logic                result_wren,
    output dct_pkg::elem_addr_t result_addr,
    output dct_pkg::sample_t    result_data,
    output logic                finished
);
    import dct_pkg::*;

    ucode_t     uop;
    spad_addr_t spad_read_addr;
    sample_t    spad_read_data;
    logic       spad_wren;
    spad_addr_t spad_write_addr;
    sample_t    spad_write_data;

    dct_control ctrl0 (
        .clock    (clock),
        .nreset   (nreset),
        .uop      (uop),
        .finished (finished)
    );

    dct_datapath dp0 (
        .clock           (clock),
        .nreset          (nreset),
        .uop             (uop),
        .fetch_addr      (fetch_addr),
        .src_data        (src_data),
        .spad_read_addr  (spad_read_addr),
        .spad_read_data  (spad_read_data),
        .spad_wren       (spad_wren),
        .spad_write_addr (spad_write_addr),
        .spad_write_data (spad_write_data),
        .result_wren     (result_wren),
        .result_addr     (result_addr),
        .result_data     (result_data)
    );

    dct_scratchpad #(
        .SPAD_DEPTH (SPAD_DEPTH)
    ) spad0 (
        .clock      (clock),
        .read_addr  (spad_read_addr),
        .read_data  (spad_read_data),
        .write_en   (spad_wren),
        .write_addr (spad_write_addr),
        .write_data (spad_write_data)
    );

endmodule

//--- bench/tb_input_memory.sv
`timescale 1ns/1ps

module tb_input_memory (
    input  logic                clock,
    input  dct_pkg::elem_addr_t read_addr,
    output dct_pkg::sample_t    read_data,
    input  logic                load_en,    // bench side load port
    input  dct_pkg::elem_addr_t load_addr,
    input  dct_pkg::sample_t    load_data
);
    import dct_pkg::*;

    // eight input samples of one transform
    sample_t mem [8];

    always_ff @(posedge clock) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
        read_data <= mem[read_addr];    // one cycle read latency
    end

endmodule

//--- bench/tb_loeffler_dct_8.sv
`timescale 1ns/1ps

module tb_loeffler_dct_8;
    import dct_pkg::*;

    localparam int  STEPS        = int'(UCODE_LEN);
    localparam int  RESET_CYCLES = 16;
    localparam int  NUM_RUNS     = 25;  // zero, two constants, 20 random, abort and restart
    localparam int  TIMEOUT      = NUM_RUNS * (STEPS + 20) + 100;
    localparam real TOL          = 6.0;

    logic        clock = 1'b0;
    logic        nreset;
    elem_addr_t  fetch_addr;
    sample_t     src_data;
    logic        result_wren;
    elem_addr_t  result_addr;
    sample_t     result_data;
    logic        finished;
    logic        load_en;
    elem_addr_t  load_addr;
    sample_t     load_data;

    sample_t     vec [8];           // current input vector
    real         expect_out [8];
    logic [15:0] lfsr_state;
    int          error_count  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          cycle_count  = 0;

    always #4 clock = ~clock;

    loeffler_dct_8 #(.SPAD_DEPTH(24)) dut0 (
        .clock       (clock),
        .nreset      (nreset),
        .fetch_addr  (fetch_addr),
        .src_data    (src_data),
        .result_wren (result_wren),
        .result_addr (result_addr),
        .result_data (result_data),
        .finished    (finished)
    );

    tb_input_memory inmem0 (
        .clock     (clock),
        .read_addr (fetch_addr),
        .read_data (src_data),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    // watchdog
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT);
            $display("Something failed");
            $finish;
        end
    end

    task automatic value_fail(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic problem(input string msg);
        $display("Error at %0t: %s", $time, msg);
        error_count++;
    endtask

    // galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic set_random();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                lfsr_state = lfsr_next(lfsr_state);
                b[j]       = lfsr_state[0];
            end
            vec[i] = {{8{b[7]}}, b};    // -128..127 raw
        end
    endtask

    task automatic set_constant(input sample_t v);
        for (int i = 0; i < 8; i++) begin
            vec[i] = v;
        end
    endtask

    // flowgraph in real arithmetic on raw 7q8 units
    task automatic reference_model();
        real pi, k3c, k3s, k1c, k1s, r6c, r6s, r2;
        real x [8];
        real a [4];
        real sp4, sp5, sp6, sp7, sp8, sp9, sp10, sp11;
        real sp12, sp13, sp14, sp15, sp20, sp21, sp22, sp23;
        int  xi;
        pi  = 3.14159265358979;
        k3c = $cos(3.0 * pi / 16.0);
        k3s = $sin(3.0 * pi / 16.0);
        k1c = $cos(pi / 16.0);
        k1s = $sin(pi / 16.0);
        r2  = $sqrt(2.0);
        r6c = r2 * $cos(6.0 * pi / 16.0);
        r6s = r2 * $sin(6.0 * pi / 16.0);
        for (int i = 0; i < 8; i++) begin
            xi   = vec[i];
            x[i] = $itor(xi);
        end
        for (int i = 0; i < 4; i++) begin
            a[i] = x[i] + x[7-i];
        end
        sp4  = x[3] - x[4];
        sp5  = x[2] - x[5];
        sp6  = x[1] - x[6];
        sp7  = x[0] - x[7];
        sp8  = a[0] + a[3];
        sp9  = a[1] + a[2];
        sp10 = a[1] - a[2];
        sp11 = a[0] - a[3];
        expect_out[0] = (sp8 + sp9) * r2 / 4.0;
        expect_out[4] = (sp8 - sp9) * r2 / 4.0;
        expect_out[2] = sp10 * r6c + sp11 * r6s;
        expect_out[6] = -sp10 * r6s + sp11 * r6c;
        sp12 = sp4 * k3c + sp7 * k3s;
        sp15 = -sp4 * k3s + sp7 * k3c;
        sp13 = sp5 * k1c + sp6 * k1s;
        sp14 = -sp5 * k1s + sp6 * k1c;
        sp20 = sp12 + sp14;
        sp21 = sp15 - sp13;
        sp22 = sp12 - sp14;
        sp23 = sp13 + sp15;
        expect_out[1] = sp20 + sp23;
        expect_out[7] = sp23 - sp20;
        expect_out[3] = sp21 * r2;
        expect_out[5] = sp22 * r2;
    endtask

    task automatic check_close(input int idx, input sample_t got, input real tol);
        int  gi;
        real diff;
        gi   = got;
        diff = $itor(gi) - expect_out[idx];
        assert (diff <= tol && diff >= -tol) else
            value_fail($sformatf("out%0d = %0d, expected %0.2f", idx, got, expect_out[idx]));
    endtask

    // entered and left on a falling edge with the memory loaded while reset is held
    task automatic reset_and_load();
        nreset = 1'b1;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            load_en   = (c < 8);
            load_addr = elem_addr_t'(c % 8);
            load_data = vec[c % 8];
            @(posedge clock);
            @(negedge clock);
            assert (!result_wren && !finished) else
                value_fail("result_wren or finished high during reset");
        end
        load_en = 1'b0;
    endtask

    task automatic abort_transform(input int cycles);
        reset_and_load();
        nreset = 1'b0;
        repeat (cycles) begin
            @(posedge clock);
            @(negedge clock);
        end
    endtask

    task automatic run_transform(input string name, input real tol);
        int      k;
        int      errs_before;
        bit      seen [8];
        sample_t got [8];
        errs_before = error_count;
        for (int i = 0; i < 8; i++) begin
            seen[i] = 1'b0;
            got[i]  = '0;
        end
        reference_model();
        reset_and_load();
        nreset = 1'b0;
        k      = 0;
        #1;
        assert (!result_wren && !finished) else
            value_fail("result_wren or finished high at reset release");
        while (!finished && k < STEPS + 20) begin
            @(posedge clock);
            @(negedge clock);
            k++;
            if (k == 1) begin
                assert (!result_wren && !finished) else
                    value_fail("result_wren or finished high on first cycle after reset");
            end
            if (result_wren) begin
                assert (!finished) else
                    value_fail($sformatf("out%0d written after finished", result_addr));
                assert (!seen[result_addr]) else
                    value_fail($sformatf("out%0d written twice", result_addr));
                seen[result_addr] = 1'b1;
                got[result_addr]  = result_data;
            end
        end
        assert (finished) else
            problem("finished never rose");
        assert (k == STEPS - 1) else
            value_fail($sformatf("finished rose after %0d cycles, expected %0d", k, STEPS - 1));
        // it must hold until the next reset
        repeat (3) begin
            @(posedge clock);
            @(negedge clock);
            assert (finished && !result_wren) else
                value_fail("finished dropped or a late write after the transform");
        end
        for (int i = 0; i < 8; i++) begin
            assert (seen[i]) else
                problem($sformatf("result %0d was never written", i));
            if (seen[i]) begin
                check_close(i, got[i], tol);
            end
        end
        tests_run++;
        if (error_count > errs_before) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    initial begin
        nreset     = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        lfsr_state = 16'd34233;
        @(negedge clock);

        set_constant(16'sd0);
        run_transform("all zero", 0.0);
        set_constant(16'sd100);
        run_transform("constant 100", TOL);
        set_constant(-16'sd77);
        run_transform("constant -77", TOL);

        for (int r = 0; r < 20; r++) begin
            set_random();
            run_transform($sformatf("random %0d", r), TOL);
        end

        // reset in the middle of a transform before a fresh vector
        set_random();
        abort_transform(25);
        set_random();
        run_transform("restart after reset", TOL);

        $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- compile.f
hdl/dct_pkg.sv
hdl/dct_multiplier.sv
hdl/dct_scratchpad.sv
hdl/dct_control.sv
hdl/dct_datapath.sv
hdl/loeffler_dct_8.sv
bench/tb_input_memory.sv
bench/tb_loeffler_dct_8.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the DCT testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_loeffler_dct_8 -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_loeffler_dct_8 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Everything OK"; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi
